//--- hdl/lsu_pkg.sv
// Load/store unit package: tag and parameter word widths, operation flag positions, fault bound.
package lsu_pkg;

	// Destination tag.
	localparam int LSU_RB = 2;                  // Rename bits, one word.
	localparam int LSU_TAG_W = 5 + LSU_RB;      // Register index plus rename bits.

	// Operation flags.
	localparam int LSU_OP_W = 13;               // One-hot, one per operation.

	// Parameter word, MSB first: {flags, tag, op1 (address), op2 (store data)}.
	localparam int LSU_EXEPARAM_W = LSU_OP_W + LSU_TAG_W + 64 + 64;

	// Flag positions inside the flag field, lb sits at the top.
	localparam int OP_LB      = 12;
	localparam int OP_LH      = 11;
	localparam int OP_LW      = 10;
	localparam int OP_LD      = 9;
	localparam int OP_LBU     = 8;
	localparam int OP_LHU     = 7;
	localparam int OP_LWU     = 6;
	localparam int OP_SB      = 5;
	localparam int OP_SH      = 4;
	localparam int OP_SW      = 3;
	localparam int OP_SD      = 2;
	localparam int OP_FENCE_I = 1;
	localparam int OP_FENCE   = 0;

	// Any address bit from here upward flags an access fault.
	localparam int LSU_ADDR_HI_LSB = 32;

endpackage

//--- hdl/axil_data_ram.sv
// AXI-Lite data RAM: doubleword array, byte strobes, request and response delay counters.
`timescale 1ns/1ps

module axil_data_ram #(
	parameter int DEPTH      = 256,
	parameter int RESP_DELAY = 2
) (
	input  logic        CLK,
	input  logic        reset,

	input  logic [63:0] awaddr,
	input  logic [2:0]  awprot,
	input  logic        awvalid,
	output logic        awready,

	input  logic [63:0] wdata,
	input  logic [7:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,

	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,

	input  logic [63:0] araddr,
	input  logic [2:0]  arprot,
	input  logic        arvalid,
	output logic        arready,

	output logic [63:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready
);

	localparam int IDX_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(RESP_DELAY + 2);
	localparam logic [CNT_W-1:0] DLY = CNT_W'(RESP_DELAY);

	logic [63:0]      mem [DEPTH];

	logic [IDX_W-1:0] aw_idx;
	logic [IDX_W-1:0] ar_idx;
	logic             w_req;
	logic             w_hs;
	logic             ar_hs;
	logic             w_busy;
	logic             r_busy;
	logic [CNT_W-1:0] w_cnt;
	logic [CNT_W-1:0] r_cnt;

	// Counts idle request cycles, then cycles since the accepted beat.
	function automatic logic [CNT_W-1:0] cnt_next(
		input logic             busy,
		input logic             req,
		input logic             req_hs,
		input logic             rsp_hs,
		input logic [CNT_W-1:0] cnt
	);
		if (req_hs) begin
			return CNT_W'(1); // Accept cycle counts as the first.
		end else if (rsp_hs || (!busy && !req)) begin
			return '0;
		end else if (cnt < DLY) begin
			return cnt + 1'b1;
		end
		return cnt;
	endfunction

	assign aw_idx = awaddr[3 +: IDX_W]; // Wraps modulo DEPTH.
	assign ar_idx = araddr[3 +: IDX_W];

	// Address and data beats are taken together.
	assign w_req   = awvalid & wvalid;
	assign awready = w_req & ~w_busy & (w_cnt >= DLY);
	assign wready  = awready;
	assign w_hs    = awvalid & awready;
	assign bvalid  = w_busy & (w_cnt >= DLY);
	assign bresp   = 2'b00; // OKAY.

	assign arready = arvalid & ~r_busy & (r_cnt >= DLY);
	assign ar_hs   = arvalid & arready;
	assign rvalid  = r_busy & (r_cnt >= DLY);
	assign rresp   = 2'b00;

	always_ff @(posedge CLK) begin
		if (reset) begin
			w_busy <= 1'b0;
			w_cnt  <= '0;
			r_busy <= 1'b0;
			r_cnt  <= '0;
		end else begin
			w_cnt <= cnt_next(w_busy, w_req, w_hs, bvalid & bready, w_cnt);
			r_cnt <= cnt_next(r_busy, arvalid, ar_hs, rvalid & rready, r_cnt);
			if (w_hs) begin
				w_busy <= 1'b1;
			end else if (bvalid & bready) begin
				w_busy <= 1'b0;
			end
			if (ar_hs) begin
				r_busy <= 1'b1;
			end else if (rvalid & rready) begin
				r_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (w_hs) begin
			for (int i = 0; i < 8; i++) begin
				if (wstrb[i]) begin
					mem[aw_idx][8*i +: 8] <= wdata[8*i +: 8];
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (ar_hs) begin
			rdata <= mem[ar_idx]; // Stable until the response is taken.
		end
	end

endmodule

//--- hdl/lsu.sv
// Load/store unit: issue decode, AXI-Lite master, load extension, writeback, flush and fault logic.
`timescale 1ns/1ps

module lsu #(
	parameter int RB = lsu_pkg::LSU_RB
) (
	input  logic                                CLK,
	input  logic                                reset,
	input  logic                                flush,

	input  logic                                exeparam_valid,
	input  logic [lsu_pkg::LSU_EXEPARAM_W-1:0]  exeparam,
	output logic                                exeparam_ready,

	output logic                                fencei_valid,
	output logic                                writeback_valid,
	output logic [63:0]                         writeback_data,
	output logic [lsu_pkg::LSU_TAG_W-1:0]       writeback_tag,
	output logic                                access_fault,

	output logic [63:0]                         awaddr,
	output logic [2:0]                          awprot,
	output logic                                awvalid,
	input  logic                                awready,

	output logic [63:0]                         wdata,
	output logic [7:0]                          wstrb,
	output logic                                wvalid,
	input  logic                                wready,

	input  logic [1:0]                          bresp,
	input  logic                                bvalid,
	output logic                                bready,

	output logic [63:0]                         araddr,
	output logic [2:0]                          arprot,
	output logic                                arvalid,
	input  logic                                arready,

	input  logic [63:0]                         rdata,
	input  logic [1:0]                          rresp,
	input  logic                                rvalid,
	output logic                                rready
);
	import lsu_pkg::*;

	localparam int TAG_W    = 5 + RB;
	localparam int OP1_LSB  = 64;
	localparam int TAG_LSB  = 128;
	localparam int FLAG_MSB = LSU_EXEPARAM_W - 1;

	logic [LSU_OP_W-1:0]       op_in;
	logic [63:0]               addr_in;
	logic                      is_load_in;
	logic                      is_store_in;
	logic                      is_fence_in;
	logic                      fault_in;

	logic [LSU_EXEPARAM_W-1:0] param_q;
	logic [LSU_OP_W-1:0]       op_q;

	logic                      aw_set;
	logic                      ar_set;
	logic                      b_hs;
	logic                      r_hs;

	logic                      w_pend;
	logic                      w_inval;
	logic                      r_pend;
	logic                      r_inval;
	logic                      busy;
	logic                      wb_set;

	logic [1:0]                ld_size;
	logic                      ld_unsigned;
	logic [63:0]               load_ext;

	// Decode of the word presented at issue.
	assign op_in   = exeparam[FLAG_MSB -: LSU_OP_W];
	assign addr_in = exeparam[OP1_LSB +: 64];

	assign is_load_in  = op_in[OP_LB] | op_in[OP_LH] | op_in[OP_LW] | op_in[OP_LD]
		| op_in[OP_LBU] | op_in[OP_LHU] | op_in[OP_LWU];
	assign is_store_in = op_in[OP_SB] | op_in[OP_SH] | op_in[OP_SW] | op_in[OP_SD];
	assign is_fence_in = op_in[OP_FENCE_I] | op_in[OP_FENCE];
	assign fault_in    = |addr_in[63:LSU_ADDR_HI_LSB];

	assign fencei_valid = exeparam_valid & op_in[OP_FENCE_I]; // Same-cycle strobe.

	always_ff @(posedge CLK) begin
		if (exeparam_valid) begin
			param_q <= exeparam; // Operands held for the bus.
		end
	end

	assign op_q          = param_q[FLAG_MSB -: LSU_OP_W];
	assign writeback_tag = param_q[TAG_LSB +: TAG_W];

	// Request side of the bus.
	assign awaddr = param_q[OP1_LSB +: 64];
	assign araddr = param_q[OP1_LSB +: 64];
	assign wdata  = param_q[63:0];
	assign awprot = 3'b000;
	assign arprot = 3'b001; // Privileged data access.

	// Store size to lanes, always from byte 0.
	assign wstrb = ({8{op_q[OP_SB]}} & 8'h01)
		| ({8{op_q[OP_SH]}} & 8'h03)
		| ({8{op_q[OP_SW]}} & 8'h0f)
		| ({8{op_q[OP_SD]}} & 8'hff);

	assign aw_set = exeparam_valid & is_store_in & ~flush;
	assign ar_set = exeparam_valid & is_load_in & ~flush;
	assign b_hs   = bvalid & bready;
	assign r_hs   = rvalid & rready;

	always_ff @(posedge CLK) begin
		if (reset) begin
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
			arvalid <= 1'b0;
			bready  <= 1'b0;
			rready  <= 1'b0;
		end else begin
			if (aw_set) begin
				awvalid <= 1'b1;
			end else if (awready) begin
				awvalid <= 1'b0; // Held until taken.
			end
			if (aw_set) begin
				wvalid <= 1'b1;
			end else if (wready) begin
				wvalid <= 1'b0;
			end
			if (ar_set) begin
				arvalid <= 1'b1;
			end else if (arready) begin
				arvalid <= 1'b0;
			end
			bready <= bvalid & ~bready; // One-cycle accept pulse.
			rready <= rvalid & ~rready;
		end
	end

	// Size and sign of the load in flight.
	always_ff @(posedge CLK) begin
		if (ar_set) begin
			ld_unsigned <= op_in[OP_LBU] | op_in[OP_LHU] | op_in[OP_LWU];
			if (op_in[OP_LB] | op_in[OP_LBU]) begin
				ld_size <= 2'd0;
			end else if (op_in[OP_LH] | op_in[OP_LHU]) begin
				ld_size <= 2'd1;
			end else if (op_in[OP_LW] | op_in[OP_LWU]) begin
				ld_size <= 2'd2;
			end else begin
				ld_size <= 2'd3;
			end
		end
	end

	always_comb begin
		case (ld_size)
			2'd0: load_ext = {{56{rdata[7] & ~ld_unsigned}}, rdata[7:0]};
			2'd1: load_ext = {{48{rdata[15] & ~ld_unsigned}}, rdata[15:0]};
			2'd2: load_ext = {{32{rdata[31] & ~ld_unsigned}}, rdata[31:0]};
			default: load_ext = rdata;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (exeparam_valid) begin
			writeback_data <= '0; // Fences and stores return zero.
		end else if (r_hs) begin
			writeback_data <= load_ext;
		end
	end

	// Per-direction tracking, a flush marks the pending access as dead.
	always_ff @(posedge CLK) begin
		if (reset) begin
			w_pend  <= 1'b0;
			w_inval <= 1'b0;
			r_pend  <= 1'b0;
			r_inval <= 1'b0;
		end else begin
			if (aw_set) begin
				w_pend <= 1'b1;
			end else if (b_hs) begin
				w_pend <= 1'b0;
			end
			if (b_hs) begin
				w_inval <= 1'b0;
			end else if (w_pend & flush) begin
				w_inval <= 1'b1;
			end
			if (ar_set) begin
				r_pend <= 1'b1;
			end else if (r_hs) begin
				r_pend <= 1'b0;
			end
			if (r_hs) begin
				r_inval <= 1'b0;
			end else if (r_pend & flush) begin
				r_inval <= 1'b1;
			end
		end
	end

	assign busy           = w_pend | r_pend;
	assign exeparam_ready = ~busy & ~exeparam_valid; // One operation at a time.

	assign wb_set = ((b_hs & ~w_inval) | (r_hs & ~r_inval)
		| (exeparam_valid & is_fence_in)) & ~flush;

	always_ff @(posedge CLK) begin
		if (reset) begin
			writeback_valid <= 1'b0;
		end else begin
			writeback_valid <= wb_set;
		end
	end

	// Sticky until flushed. The access itself still goes out.
	always_ff @(posedge CLK) begin
		if (reset) begin
			access_fault <= 1'b0;
		end else if (flush) begin
			access_fault <= 1'b0;
		end else if (exeparam_valid & fault_in) begin
			access_fault <= 1'b1;
		end
	end

endmodule

//--- hdl/lsu_subsys.sv
// Load/store subsystem top: load/store unit and AXI-Lite data RAM on an internal bus.
`timescale 1ns/1ps

module lsu_subsys #(
	parameter int RB         = lsu_pkg::LSU_RB,
	parameter int DEPTH      = 256,
	parameter int RESP_DELAY = 2
) (
	input  logic                               CLK,
	input  logic                               reset,
	input  logic                               flush,
	input  logic                               exeparam_valid,
	input  logic [lsu_pkg::LSU_EXEPARAM_W-1:0] exeparam,
	output logic                               exeparam_ready,
	output logic                               fencei_valid,
	output logic                               writeback_valid,
	output logic [63:0]                        writeback_data,
	output logic [lsu_pkg::LSU_TAG_W-1:0]      writeback_tag,
	output logic                               access_fault
);

	// Internal AXI-Lite bus.
	logic [63:0] awaddr;
	logic [2:0]  awprot;
	logic        awvalid;
	logic        awready;
	logic [63:0] wdata;
	logic [7:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [63:0] araddr;
	logic [2:0]  arprot;
	logic        arvalid;
	logic        arready;
	logic [63:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;

	lsu #(
		.RB(RB)
	) u_lsu (
		.CLK(CLK),
		.reset(reset),
		.flush(flush),
		.exeparam_valid(exeparam_valid),
		.exeparam(exeparam),
		.exeparam_ready(exeparam_ready),
		.fencei_valid(fencei_valid),
		.writeback_valid(writeback_valid),
		.writeback_data(writeback_data),
		.writeback_tag(writeback_tag),
		.access_fault(access_fault),
		.awaddr(awaddr), .awprot(awprot), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arprot(arprot), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	axil_data_ram #(
		.DEPTH(DEPTH),
		.RESP_DELAY(RESP_DELAY)
	) u_ram (
		.CLK(CLK),
		.reset(reset),
		.awaddr(awaddr), .awprot(awprot), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arprot(arprot), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

endmodule

//--- tb/lsu_subsys_sva.sv
// Bound checks on the load/store subsystem: AXI-Lite request hold, writeback pulse, issue, reset.
`timescale 1ns/1ps

module lsu_subsys_sva (
	input logic                               CLK,
	input logic                               reset,
	input logic                               exeparam_valid,
	input logic [lsu_pkg::LSU_EXEPARAM_W-1:0] exeparam,
	input logic                               exeparam_ready,
	input logic                               fencei_valid,
	input logic                               writeback_valid,
	input logic                               access_fault,
	input logic [63:0]                        awaddr,
	input logic                               awvalid,
	input logic                               awready,
	input logic [63:0]                        wdata,
	input logic                               wvalid,
	input logic                               wready,
	input logic [63:0]                        araddr,
	input logic                               arvalid,
	input logic                               arready,
	input logic                               bready,
	input logic                               rready
);
	import lsu_pkg::*;

	localparam int FLAG_LSB = LSU_EXEPARAM_W - LSU_OP_W;

	int   fail_count = 0; // Read by the testbench.
	logic mem_op;

	// Loads and stores fill the flag field above the fences.
	assign mem_op = |exeparam[FLAG_LSB + OP_SD +: OP_LB - OP_SD + 1];

	function automatic void report(input string what);
		$error("%s", what);
		fail_count++;
	endfunction

	aw_hold: assert property (@(posedge CLK) disable iff (reset)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else report("awvalid dropped or awaddr moved before awready");

	w_hold: assert property (@(posedge CLK) disable iff (reset)
		wvalid && !wready |=> wvalid && $stable(wdata))
		else report("wvalid dropped or wdata moved before wready");

	ar_hold: assert property (@(posedge CLK) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else report("arvalid dropped or araddr moved before arready");

	wb_pulse: assert property (@(posedge CLK) disable iff (reset)
		writeback_valid |=> !writeback_valid)
		else report("writeback_valid high two cycles in a row");

	// A load or store keeps the issue side closed past its issue cycle.
	issue_rule: assert property (@(posedge CLK) disable iff (reset)
		exeparam_valid && mem_op |-> !exeparam_ready ##1 !exeparam_ready)
		else report("exeparam_ready high in or right after a load or store issue");

	// Fences stay off the bus, and only fence.i raises the strobe.
	fence_quiet: assert property (@(posedge CLK) disable iff (reset)
		exeparam_valid && (exeparam[FLAG_LSB + OP_FENCE] || exeparam[FLAG_LSB + OP_FENCE_I])
		|=> !awvalid && !wvalid && !arvalid)
		else report("fence started a bus transaction");

	fencei_strobe: assert property (@(posedge CLK) disable iff (reset)
		fencei_valid |-> exeparam_valid && exeparam[FLAG_LSB + OP_FENCE_I])
		else report("fencei_valid outside a fence.i issue cycle");

	reset_state: assert property (@(posedge CLK)
		reset |=> !awvalid && !wvalid && !arvalid && !bready && !rready
			&& !writeback_valid && !access_fault && exeparam_ready)
		else report("control outputs not idle after reset");

endmodule

bind lsu_subsys lsu_subsys_sva u_sva (
	.CLK(CLK), .reset(reset),
	.exeparam_valid(exeparam_valid), .exeparam(exeparam), .exeparam_ready(exeparam_ready),
	.fencei_valid(fencei_valid), .writeback_valid(writeback_valid),
	.access_fault(access_fault),
	.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
	.wdata(wdata), .wvalid(wvalid), .wready(wready),
	.araddr(araddr), .arvalid(arvalid), .arready(arready),
	.bready(bready), .rready(rready)
);

//--- tb/lsu_subsys_tb.sv
// Testbench for the load/store subsystem: clock, reset, operation tasks, memory model, reporting.
`timescale 1ns/1ps

module lsu_subsys_tb;
	import lsu_pkg::*;

	localparam int PERIOD     = 40;
	localparam int RESP_DELAY = 2;
	localparam int DEPTH      = 256;
	localparam int OP_BOUND   = 4 * RESP_DELAY + 8;      // Worst case cycles per operation.
	localparam int NUM_OPS    = 27;
	localparam int WATCHDOG   = NUM_OPS * OP_BOUND + 40; // Reset and idle cycles on top.
	localparam logic [63:0] SIGN_BITS = 64'h8000_0000_8000_8080;

	logic                      CLK = 1'b0;
	logic                      reset;
	logic                      flush;
	logic                      exeparam_valid;
	logic [LSU_EXEPARAM_W-1:0] exeparam;
	logic                      exeparam_ready;
	logic                      fencei_valid;
	logic                      writeback_valid;
	logic [63:0]               writeback_data;
	logic [LSU_TAG_W-1:0]      writeback_tag;
	logic                      access_fault;

	logic [7:0] model [DEPTH*8]; // Byte image of the RAM, built from issued stores.
	int         errors;
	int         passed;
	int         failed;
	int         mark;
	logic       fencei_seen;

	lsu_subsys #(.RB(LSU_RB), .DEPTH(DEPTH), .RESP_DELAY(RESP_DELAY)) UUT (
		.CLK(CLK), .reset(reset), .flush(flush),
		.exeparam_valid(exeparam_valid), .exeparam(exeparam), .exeparam_ready(exeparam_ready),
		.fencei_valid(fencei_valid), .writeback_valid(writeback_valid),
		.writeback_data(writeback_data), .writeback_tag(writeback_tag),
		.access_fault(access_fault)
	);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	initial begin
		#(WATCHDOG * PERIOD);
		$display("watchdog expired, run did not end within %0d cycles", WATCHDOG);
		$display("*** TEST FAILED ***");
		$finish;
	end

	function automatic logic [LSU_OP_W-1:0] op_flag(input int pos);
		return LSU_OP_W'(1) << pos;
	endfunction

	function automatic int byte_index(input logic [63:0] addr, input int lane);
		return int'((addr >> 3) % 64'(DEPTH)) * 8 + lane; // Doubleword wraps modulo DEPTH.
	endfunction

	// Low bytes of the doubleword, then sign or zero fill.
	function automatic logic [63:0] expected_load(input logic [63:0] addr, input int nbytes,
			input bit sign_ext);
		logic [63:0] value;
		value = '0;
		for (int i = 0; i < nbytes; i++) begin
			value[8*i +: 8] = model[byte_index(addr, i)];
		end
		if (sign_ext && value[8*nbytes-1]) begin
			for (int i = nbytes; i < 8; i++) begin
				value[8*i +: 8] = 8'hff;
			end
		end
		return value;
	endfunction

	task automatic compare_value(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		assert (act === exp) else begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	// Issues on the next falling edge, returns on the falling edge after the issue cycle.
	task automatic issue_op(input logic [LSU_OP_W-1:0] flags, input logic [LSU_TAG_W-1:0] tag,
			input logic [63:0] addr, input logic [63:0] sdata);
		@(negedge CLK);
		assert (exeparam_ready) else begin
			$display("exeparam_ready was low when an operation was due");
			errors++;
		end
		exeparam = {flags, tag, addr, sdata};
		exeparam_valid = 1'b1;
		@(posedge CLK);
		fencei_seen = fencei_valid;
		@(negedge CLK);
		exeparam_valid = 1'b0;
	endtask

	task automatic wait_writeback;
		int cycles;
		cycles = 1;
		while (!writeback_valid && cycles < OP_BOUND) begin
			assert (!exeparam_ready) else begin
				$display("exeparam_ready rose before the writeback");
				errors++;
			end
			@(negedge CLK);
			cycles++;
		end
		assert (writeback_valid) else begin
			$display("no writeback within %0d cycles of issue", OP_BOUND);
			errors++;
		end
	endtask

	task automatic store_op(input int op, input logic [LSU_TAG_W-1:0] tag,
			input logic [63:0] addr, input logic [63:0] data, input int nbytes);
		for (int i = 0; i < nbytes; i++) begin
			model[byte_index(addr, i)] = data[8*i +: 8];
		end
		issue_op(op_flag(op), tag, addr, data);
		wait_writeback();
		compare_value("writeback_tag", 64'(tag), 64'(writeback_tag));
	endtask

	task automatic load_check(input int op, input logic [LSU_TAG_W-1:0] tag,
			input logic [63:0] addr, input int nbytes, input bit sign_ext);
		issue_op(op_flag(op), tag, addr, 64'h0);
		wait_writeback();
		compare_value("writeback_data", expected_load(addr, nbytes, sign_ext), writeback_data);
		compare_value("writeback_tag", 64'(tag), 64'(writeback_tag));
	endtask

	// Bound assertion failures count against the test that was running.
	task automatic end_test(input string name);
		int total;
		total = errors + UUT.u_sva.fail_count;
		if (total == mark) begin
			passed++;
			$display("test %s: ok", name);
		end else begin
			failed++;
			$display("test %s: failed with %0d errors", name, total - mark);
		end
		mark = total;
	endtask

	initial begin
		logic [63:0] addr;
		logic [63:0] addr2;
		logic [63:0] data;
		int          cycles;
		logic        resp_seen;

		void'($urandom(32'h0c46cb13));
		reset = 1'b1;
		flush = 1'b0;
		exeparam_valid = 1'b0;
		exeparam = '0;
		errors = 0;
		passed = 0;
		failed = 0;
		mark = 0;
		fencei_seen = 1'b0;
		repeat (5) @(negedge CLK);
		reset = 1'b0;
		repeat (2) @(negedge CLK);

		for (int it = 0; it < 2; it++) begin
			addr = 64'($urandom_range(DEPTH - 1)) << 3;
			data = {$urandom, $urandom};
			data = (it == 0) ? (data & ~SIGN_BITS) : (data | SIGN_BITS); // Both fill kinds.
			store_op(OP_SD, LSU_TAG_W'(it + 1), addr, data, 8);
			load_check(OP_LB, 7'h10, addr, 1, 1'b1);
			load_check(OP_LH, 7'h11, addr, 2, 1'b1);
			load_check(OP_LW, 7'h12, addr, 4, 1'b1);
			load_check(OP_LD, 7'h13, addr, 8, 1'b0);
			load_check(OP_LBU, 7'h14, addr, 1, 1'b0);
			load_check(OP_LHU, 7'h15, addr, 2, 1'b0);
			load_check(OP_LWU, 7'h16, addr, 4, 1'b0);
		end
		end_test("store_load_round_trip");

		addr2 = 64'h0000_0000_0000_0400;
		store_op(OP_SD, 7'h21, addr2, 64'h0123_4567_89ab_cdef, 8);
		store_op(OP_SB, 7'h22, addr2, 64'hffff_ffff_ffff_ff5a, 1);
		load_check(OP_LD, 7'h23, addr2, 8, 1'b0);
		store_op(OP_SH, 7'h24, addr2, 64'heeee_eeee_eeee_c3a5, 2);
		load_check(OP_LD, 7'h25, addr2, 8, 1'b0);
		end_test("byte_strobes");

		issue_op(op_flag(OP_FENCE), 7'h31, 64'h0, 64'h0);
		assert (writeback_valid && !fencei_seen) else begin
			$display("fence missed its one-cycle writeback or raised fencei_valid");
			errors++;
		end
		compare_value("writeback_tag", 64'h31, 64'(writeback_tag));
		issue_op(op_flag(OP_FENCE_I), 7'h32, 64'h0, 64'h0);
		assert (writeback_valid && fencei_seen) else begin
			$display("fence.i missed its one-cycle writeback or its fencei_valid strobe");
			errors++;
		end
		compare_value("writeback_tag", 64'h32, 64'(writeback_tag));
		end_test("fences");

		issue_op(op_flag(OP_LD), 7'h41, addr, 64'h0);
		flush = 1'b1;
		@(negedge CLK);
		flush = 1'b0;
		cycles = 0;
		resp_seen = 1'b0;
		while (!exeparam_ready && cycles < OP_BOUND) begin
			assert (!writeback_valid) else begin
				$display("flushed load still wrote back");
				errors++;
			end
			resp_seen = resp_seen | UUT.rready; // Response of the flushed load taken.
			@(negedge CLK);
			cycles++;
		end
		assert (exeparam_ready && !writeback_valid && resp_seen) else begin
			$display("flushed load did not finish quietly on the bus");
			errors++;
		end
		load_check(OP_LD, 7'h42, addr, 8, 1'b0);
		end_test("flush");

		compare_value("access_fault", 64'h0, 64'(access_fault));
		issue_op(op_flag(OP_LD), 7'h51, addr2 | 64'h0000_0100_0000_0000, 64'h0);
		compare_value("access_fault", 64'h1, 64'(access_fault));
		wait_writeback();
		compare_value("writeback_data", expected_load(addr2, 8, 1'b0), writeback_data);
		issue_op(op_flag(OP_FENCE), 7'h52, 64'h0, 64'h0);
		compare_value("access_fault", 64'h1, 64'(access_fault)); // Still sticky.
		flush = 1'b1;
		@(negedge CLK);
		flush = 1'b0;
		compare_value("access_fault", 64'h0, 64'(access_fault));
		end_test("access_fault");

		$display("tests passed %0d, failed %0d", passed, failed);
		if (failed == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- verilog.f
hdl/lsu_pkg.sv
hdl/axil_data_ram.sv
hdl/lsu.sv
hdl/lsu_subsys.sv
tb/lsu_subsys_sva.sv
tb/lsu_subsys_tb.sv

//--- Makefile
# Verilator build and run of the load/store subsystem testbench.

VERILATOR ?= verilator
TOP       ?= lsu_subsys_tb
LOG       ?= sim.log
SEED_ARGS ?= +verilator+seed+1
RUN_ARGS  ?= +verilator+error+limit+1000
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing

PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP LOG SEED_ARGS RUN_ARGS FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
